// File: hdl/gtp_pkg.sv
package gtp_pkg;

  // Wishbone word addresses
  localparam logic [31:0] ADDR_CONTROL   = 32'd0;
  localparam logic [31:0] ADDR_STATUS    = 32'd1;
  localparam logic [31:0] ADDR_SATA_ERRS = 32'd2;
  localparam logic [31:0] ADDR_PCIE_ERRS = 32'd3;
  localparam logic [31:0] ADDR_ERR_CLEAR = 32'd4;

  // Control register single bits
  localparam int CTL_SATA_RESET = 0;
  localparam int CTL_PCIE_RESET = 1;
  localparam int CTL_INT_EN     = 2;

  // Control register fields
  localparam int CTL_PRE_AMP_LO = 4;
  localparam int CTL_PRE_AMP_HI = 5;
  localparam int CTL_TX_DIFF_LO = 8;
  localparam int CTL_TX_DIFF_HI = 11;

  // Status word bits, SATA and PCIe interleaved
  localparam int ST_SATA_PLL_DETECT = 0;
  localparam int ST_PCIE_PLL_DETECT = 1;
  localparam int ST_SATA_RESET_DONE = 2;
  localparam int ST_PCIE_RESET_DONE = 3;
  localparam int ST_SATA_LOCKED     = 4;
  localparam int ST_PCIE_LOCKED     = 5;
  localparam int ST_SATA_RX_IDLE    = 6;
  localparam int ST_PCIE_RX_IDLE    = 7;
  localparam int ST_SATA_TX_IDLE    = 8;
  localparam int ST_PCIE_TX_IDLE    = 9;
  localparam int ST_SATA_LOSS_SYNC  = 10;
  localparam int ST_PCIE_LOSS_SYNC  = 11;
  localparam int ST_SATA_ALIGNED    = 12;
  localparam int ST_PCIE_ALIGNED    = 13;

  // Byte lanes in the transceiver's per-byte error flags
  localparam int LANE_BYTES = 4;

endpackage

// File: hdl/lane_monitor.sv
`timescale 1ns/100ps

module lane_monitor
  import gtp_pkg::*;
#(
  parameter int ERR_CNT_W = 16
)(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_lane_reset,
  input  logic                  i_pll_detect,
  input  logic                  i_dcm_locked,
  input  logic                  i_reset_done,
  input  logic                  i_byte_aligned,
  input  logic [LANE_BYTES-1:0] i_disparity_error,
  input  logic [LANE_BYTES-1:0] i_not_in_table,
  input  logic                  i_clear,
  output logic                  o_error,
  output logic                  o_ready,
  output logic [ERR_CNT_W-1:0]  o_err_count
);

  logic count_en;

  // Any bad byte or lost alignment counts as an error
  assign o_error = (|i_disparity_error) || (|i_not_in_table) || !i_byte_aligned;

  // Lane is usable once out of reset with PLL and DCM settled
  assign o_ready = !i_lane_reset && i_pll_detect && i_dcm_locked && i_reset_done;

  // Only errors seen on a ready lane are counted
  assign count_en = o_error && o_ready;

  always_ff @(posedge clk) begin
    if (rst || i_lane_reset) begin
      o_err_count <= '0;
    end else if (i_clear) begin
      o_err_count <= '0;
    end else if (count_en && !(&o_err_count)) begin
      o_err_count <= o_err_count + 1'b1;
    end
  end

  // Counter only moves down through clear or reset
  a_count_monotonic: assert property (
    @(posedge clk) disable iff (rst)
    (!$past(rst) && !$past(i_lane_reset) && !$past(i_clear))
      |-> (o_err_count >= $past(o_err_count))
  ) else $error("lane_monitor: error count decreased without clear");

endmodule

// File: hdl/sata_oob_ctrl.sv
`timescale 1ns/100ps

module sata_oob_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic i_lane_reset,
  input  logic i_reset_done,
  input  logic i_comm_wake,
  input  logic i_comm_init,
  output logic o_comm_start,
  output logic o_comm_type
);

  logic wake_pending;
  logic init_pending;
  logic seq_reset;

  assign seq_reset = rst || i_lane_reset;

  always_ff @(posedge clk) begin
    if (seq_reset) begin
      o_comm_start <= 1'b0;
      o_comm_type  <= 1'b0;
      wake_pending <= 1'b0;
      init_pending <= 1'b0;
    end else if (!i_reset_done) begin
      // Drop everything while the transceiver is still coming up
      o_comm_start <= 1'b0;
      o_comm_type  <= 1'b0;
      wake_pending <= 1'b0;
      init_pending <= 1'b0;
    end else begin
      o_comm_start <= 1'b0;

      if (i_comm_wake) begin
        wake_pending <= 1'b1;
        o_comm_type  <= 1'b1;
      end

      // Init overrides the type and holds off any pending start
      if (i_comm_init) begin
        init_pending <= 1'b1;
        o_comm_type  <= 1'b0;
      end else if (init_pending) begin
        o_comm_start <= 1'b1;
        init_pending <= 1'b0;
      end else if (wake_pending) begin
        o_comm_start <= 1'b1;
        wake_pending <= 1'b0;
      end
    end
  end

  // No start pulse while the transceiver reports reset not done
  a_start_needs_done: assert property (
    @(posedge clk) disable iff (seq_reset)
    o_comm_start |-> i_reset_done
  ) else $error("sata_oob_ctrl: start high while reset done low");

endmodule

// File: hdl/wb_gtp_regs.sv
`timescale 1ns/100ps

module wb_gtp_regs
  import gtp_pkg::*;
#(
  parameter logic [1:0] RX_PREAMP = 2'h3,
  parameter logic [3:0] TX_DIFF   = 4'h6,
  parameter int         ERR_CNT_W = 16
)(
  input  logic                 clk,
  input  logic                 rst,
  // Wishbone slave
  input  logic                 i_wbs_cyc,
  input  logic                 i_wbs_stb,
  input  logic                 i_wbs_we,
  input  logic [31:0]          i_wbs_adr,
  input  logic [31:0]          i_wbs_dat,
  input  logic [3:0]           i_wbs_sel,
  output logic                 o_wbs_ack,
  output logic [31:0]          o_wbs_dat,
  output logic                 o_wbs_int,
  // Transceiver status
  input  logic                 i_sata_pll_detect,
  input  logic                 i_pcie_pll_detect,
  input  logic                 i_sata_reset_done,
  input  logic                 i_pcie_reset_done,
  input  logic                 i_sata_locked,
  input  logic                 i_pcie_locked,
  input  logic                 i_sata_rx_idle,
  input  logic                 i_pcie_rx_idle,
  input  logic                 i_sata_tx_idle,
  input  logic                 i_pcie_tx_idle,
  input  logic                 i_sata_loss_sync,
  input  logic                 i_pcie_loss_sync,
  input  logic                 i_sata_aligned,
  input  logic                 i_pcie_aligned,
  // Lane error counters
  input  logic [ERR_CNT_W-1:0] i_sata_err_count,
  input  logic [ERR_CNT_W-1:0] i_pcie_err_count,
  output logic [31:0]          o_control,
  output logic                 o_clear_counts
);

  logic [31:0] status;
  logic        access;
  logic        counts_nonzero;

  // New access only when the previous ack has been dropped
  assign access = i_wbs_cyc && i_wbs_stb && !o_wbs_ack;

  assign counts_nonzero = (i_sata_err_count != '0) || (i_pcie_err_count != '0);

  always_comb begin
    status                     = '0;
    status[ST_SATA_PLL_DETECT] = i_sata_pll_detect;
    status[ST_PCIE_PLL_DETECT] = i_pcie_pll_detect;
    status[ST_SATA_RESET_DONE] = i_sata_reset_done;
    status[ST_PCIE_RESET_DONE] = i_pcie_reset_done;
    status[ST_SATA_LOCKED]     = i_sata_locked;
    status[ST_PCIE_LOCKED]     = i_pcie_locked;
    status[ST_SATA_RX_IDLE]    = i_sata_rx_idle;
    status[ST_PCIE_RX_IDLE]    = i_pcie_rx_idle;
    status[ST_SATA_TX_IDLE]    = i_sata_tx_idle;
    status[ST_PCIE_TX_IDLE]    = i_pcie_tx_idle;
    status[ST_SATA_LOSS_SYNC]  = i_sata_loss_sync;
    status[ST_PCIE_LOSS_SYNC]  = i_pcie_loss_sync;
    status[ST_SATA_ALIGNED]    = i_sata_aligned;
    status[ST_PCIE_ALIGNED]    = i_pcie_aligned;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wbs_ack      <= 1'b0;
      o_wbs_dat      <= 32'h0;
      o_wbs_int      <= 1'b0;
      o_clear_counts <= 1'b0;
      o_control      <= 32'h0;
      o_control[CTL_PRE_AMP_HI:CTL_PRE_AMP_LO] <= RX_PREAMP;
      o_control[CTL_TX_DIFF_HI:CTL_TX_DIFF_LO] <= TX_DIFF;
    end else begin
      o_clear_counts <= 1'b0;
      o_wbs_int      <= o_control[CTL_INT_EN] && counts_nonzero;

      // Master has seen the ack
      if (o_wbs_ack && !i_wbs_stb) begin
        o_wbs_ack <= 1'b0;
      end

      if (access) begin
        if (i_wbs_we) begin
          case (i_wbs_adr)
            ADDR_CONTROL: begin
              for (int b = 0; b < 4; b++) begin
                if (i_wbs_sel[b]) begin
                  o_control[8*b +: 8] <= i_wbs_dat[8*b +: 8];
                end
              end
            end
            ADDR_ERR_CLEAR: begin
              o_clear_counts <= 1'b1;
            end
            default: begin
            end
          endcase
        end else begin
          case (i_wbs_adr)
            ADDR_CONTROL:   o_wbs_dat <= o_control;
            ADDR_STATUS:    o_wbs_dat <= status;
            ADDR_SATA_ERRS: o_wbs_dat <= 32'(i_sata_err_count);
            ADDR_PCIE_ERRS: o_wbs_dat <= 32'(i_pcie_err_count);
            default: begin
            end
          endcase
        end
        o_wbs_ack <= 1'b1;
      end
    end
  end

  // Ack only answers a strobe seen on the previous edge
  a_ack_needs_stb: assert property (
    @(posedge clk) disable iff (rst)
    $rose(o_wbs_ack) |-> $past(i_wbs_stb && i_wbs_cyc)
  ) else $error("wb_gtp_regs: ack raised without strobe");

endmodule

// File: hdl/gtp_platform_top.sv
`timescale 1ns/100ps

module gtp_platform_top
  import gtp_pkg::*;
#(
  parameter logic [1:0] RX_PREAMP = 2'h3,
  parameter logic [3:0] TX_DIFF   = 4'h6,
  parameter int         ERR_CNT_W = 16
)(
  input  logic                  clk,
  input  logic                  rst,
  // Wishbone slave
  input  logic                  i_wbs_cyc,
  input  logic                  i_wbs_stb,
  input  logic                  i_wbs_we,
  input  logic [31:0]           i_wbs_adr,
  input  logic [31:0]           i_wbs_dat,
  input  logic [3:0]            i_wbs_sel,
  output logic                  o_wbs_ack,
  output logic [31:0]           o_wbs_dat,
  output logic                  o_wbs_int,
  // SATA transceiver health
  input  logic                  i_sata_pll_detect,
  input  logic                  i_sata_reset_done,
  input  logic                  i_sata_locked,
  input  logic                  i_sata_rx_idle,
  input  logic                  i_sata_tx_idle,
  input  logic                  i_sata_loss_sync,
  input  logic                  i_sata_aligned,
  input  logic [LANE_BYTES-1:0] i_sata_disparity_error,
  input  logic [LANE_BYTES-1:0] i_sata_not_in_table,
  // PCIe transceiver health
  input  logic                  i_pcie_pll_detect,
  input  logic                  i_pcie_reset_done,
  input  logic                  i_pcie_locked,
  input  logic                  i_pcie_rx_idle,
  input  logic                  i_pcie_tx_idle,
  input  logic                  i_pcie_loss_sync,
  input  logic                  i_pcie_aligned,
  input  logic [LANE_BYTES-1:0] i_pcie_disparity_error,
  input  logic [LANE_BYTES-1:0] i_pcie_not_in_table,
  // SATA link layer OOB requests
  input  logic                  i_sata_tx_comm_wake,
  input  logic                  i_sata_tx_comm_init,
  // Transceiver control
  output logic                  o_sata_reset,
  output logic                  o_pcie_reset,
  output logic [1:0]            o_rx_pre_amp,
  output logic [3:0]            o_tx_diff_swing,
  output logic                  o_sata_comm_start,
  output logic                  o_sata_comm_type,
  output logic                  o_sata_error,
  output logic                  o_pcie_error,
  output logic                  o_platform_ready
);

  logic [31:0]          control;
  logic                 clear_counts;
  logic [ERR_CNT_W-1:0] sata_err_count;
  logic [ERR_CNT_W-1:0] pcie_err_count;

  // Lane resets follow the system reset or software
  assign o_sata_reset    = rst || control[CTL_SATA_RESET];
  assign o_pcie_reset    = rst || control[CTL_PCIE_RESET];
  assign o_rx_pre_amp    = control[CTL_PRE_AMP_HI:CTL_PRE_AMP_LO];
  assign o_tx_diff_swing = control[CTL_TX_DIFF_HI:CTL_TX_DIFF_LO];

  lane_monitor #(.ERR_CNT_W(ERR_CNT_W)) sata_mon (
    .clk               (clk),
    .rst               (rst),
    .i_lane_reset      (o_sata_reset),
    .i_pll_detect      (i_sata_pll_detect),
    .i_dcm_locked      (i_sata_locked),
    .i_reset_done      (i_sata_reset_done),
    .i_byte_aligned    (i_sata_aligned),
    .i_disparity_error (i_sata_disparity_error),
    .i_not_in_table    (i_sata_not_in_table),
    .i_clear           (clear_counts),
    .o_error           (o_sata_error),
    .o_ready           (o_platform_ready),
    .o_err_count       (sata_err_count)
  );

  // Platform readiness is judged on the SATA lane alone
  lane_monitor #(.ERR_CNT_W(ERR_CNT_W)) pcie_mon (
    .clk               (clk),
    .rst               (rst),
    .i_lane_reset      (o_pcie_reset),
    .i_pll_detect      (i_pcie_pll_detect),
    .i_dcm_locked      (i_pcie_locked),
    .i_reset_done      (i_pcie_reset_done),
    .i_byte_aligned    (i_pcie_aligned),
    .i_disparity_error (i_pcie_disparity_error),
    .i_not_in_table    (i_pcie_not_in_table),
    .i_clear           (clear_counts),
    .o_error           (o_pcie_error),
    .o_ready           (),
    .o_err_count       (pcie_err_count)
  );

  sata_oob_ctrl sata_oob (
    .clk          (clk),
    .rst          (rst),
    .i_lane_reset (o_sata_reset),
    .i_reset_done (i_sata_reset_done),
    .i_comm_wake  (i_sata_tx_comm_wake),
    .i_comm_init  (i_sata_tx_comm_init),
    .o_comm_start (o_sata_comm_start),
    .o_comm_type  (o_sata_comm_type)
  );

  wb_gtp_regs #(
    .RX_PREAMP (RX_PREAMP),
    .TX_DIFF   (TX_DIFF),
    .ERR_CNT_W (ERR_CNT_W)
  ) regs (
    .clk               (clk),
    .rst               (rst),
    .i_wbs_cyc         (i_wbs_cyc),
    .i_wbs_stb         (i_wbs_stb),
    .i_wbs_we          (i_wbs_we),
    .i_wbs_adr         (i_wbs_adr),
    .i_wbs_dat         (i_wbs_dat),
    .i_wbs_sel         (i_wbs_sel),
    .o_wbs_ack         (o_wbs_ack),
    .o_wbs_dat         (o_wbs_dat),
    .o_wbs_int         (o_wbs_int),
    .i_sata_pll_detect (i_sata_pll_detect),
    .i_pcie_pll_detect (i_pcie_pll_detect),
    .i_sata_reset_done (i_sata_reset_done),
    .i_pcie_reset_done (i_pcie_reset_done),
    .i_sata_locked     (i_sata_locked),
    .i_pcie_locked     (i_pcie_locked),
    .i_sata_rx_idle    (i_sata_rx_idle),
    .i_pcie_rx_idle    (i_pcie_rx_idle),
    .i_sata_tx_idle    (i_sata_tx_idle),
    .i_pcie_tx_idle    (i_pcie_tx_idle),
    .i_sata_loss_sync  (i_sata_loss_sync),
    .i_pcie_loss_sync  (i_pcie_loss_sync),
    .i_sata_aligned    (i_sata_aligned),
    .i_pcie_aligned    (i_pcie_aligned),
    .i_sata_err_count  (sata_err_count),
    .i_pcie_err_count  (pcie_err_count),
    .o_control         (control),
    .o_clear_counts    (clear_counts)
  );

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
  parameter int RESET_CYCLES = 8
)(
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release away from the active edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: sim/tb_gtp_platform.sv
`timescale 1ns/100ps

module tb_gtp_platform
  import gtp_pkg::*;
();

  localparam logic [1:0] TB_RX_PREAMP = 2'h2;
  localparam logic [3:0] TB_TX_DIFF   = 4'h9;
  localparam int         TB_CNT_W     = 16;
  localparam int         ACK_TIMEOUT  = 20;
  localparam int         OOB_WINDOW   = 8;

  // Control word right after reset
  localparam logic [31:0] CTL_RESET_VAL = {20'h0, TB_TX_DIFF, 2'b00, TB_RX_PREAMP, 4'h0};

  // Per lane health word: 0 pll, 1 reset done, 2 locked, 3 rx idle,
  // 4 tx idle, 5 loss sync, 6 aligned, 11:8 disparity, 15:12 not in table
  localparam logic [15:0] HEALTHY_LANE = 16'h0047;

  localparam int OP_READ  = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_HOLD  = 2;
  localparam int OP_WAKE  = 3;
  localparam int OP_INIT  = 4;
  localparam int OP_BOTH  = 5;

  localparam int SEL_RDATA  = 0;
  localparam int SEL_ACK    = 1;
  localparam int SEL_PREAMP = 2;
  localparam int SEL_SWING  = 3;
  localparam int SEL_RESETS = 4;
  localparam int SEL_READY  = 5;
  localparam int SEL_ERRORS = 6;
  localparam int SEL_INT    = 7;
  localparam int SEL_OOB    = 8;

  logic        clk;
  logic        rst;
  logic        wbs_cyc;
  logic        wbs_stb;
  logic        wbs_we;
  logic [31:0] wbs_adr;
  logic [31:0] wbs_dat;
  logic [3:0]  wbs_sel;
  logic [31:0] health;
  logic        tx_comm_wake;
  logic        tx_comm_init;

  logic        o_wbs_ack;
  logic [31:0] o_wbs_dat;
  logic        o_wbs_int;
  logic        o_sata_reset;
  logic        o_pcie_reset;
  logic [1:0]  o_rx_pre_amp;
  logic [3:0]  o_tx_diff_swing;
  logic        o_sata_comm_start;
  logic        o_sata_comm_type;
  logic        o_sata_error;
  logic        o_pcie_error;
  logic        o_platform_ready;

  // Stimulus table
  string       row_name[$];
  int          row_op[$];
  int          row_sel[$];
  logic [31:0] row_health[$];
  logic [31:0] row_addr[$];
  logic [31:0] row_data[$];
  logic [31:0] row_exp[$];

  integer      seed;
  logic [31:0] rd_data;
  logic        ack_ok;
  int          pass_count  = 0;
  int          fail_count  = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          pulse_total = 0;
  int          pulse_base  = 0;
  logic        last_type   = 1'b0;

  clk_gen #(.RESET_CYCLES(8)) clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  gtp_platform_top #(
    .RX_PREAMP (TB_RX_PREAMP),
    .TX_DIFF   (TB_TX_DIFF),
    .ERR_CNT_W (TB_CNT_W)
  ) dut_i (
    .clk                    (clk),
    .rst                    (rst),
    .i_wbs_cyc              (wbs_cyc),
    .i_wbs_stb              (wbs_stb),
    .i_wbs_we               (wbs_we),
    .i_wbs_adr              (wbs_adr),
    .i_wbs_dat              (wbs_dat),
    .i_wbs_sel              (wbs_sel),
    .o_wbs_ack              (o_wbs_ack),
    .o_wbs_dat              (o_wbs_dat),
    .o_wbs_int              (o_wbs_int),
    .i_sata_pll_detect      (health[0]),
    .i_sata_reset_done      (health[1]),
    .i_sata_locked          (health[2]),
    .i_sata_rx_idle         (health[3]),
    .i_sata_tx_idle         (health[4]),
    .i_sata_loss_sync       (health[5]),
    .i_sata_aligned         (health[6]),
    .i_sata_disparity_error (health[11:8]),
    .i_sata_not_in_table    (health[15:12]),
    .i_pcie_pll_detect      (health[16]),
    .i_pcie_reset_done      (health[17]),
    .i_pcie_locked          (health[18]),
    .i_pcie_rx_idle         (health[19]),
    .i_pcie_tx_idle         (health[20]),
    .i_pcie_loss_sync       (health[21]),
    .i_pcie_aligned         (health[22]),
    .i_pcie_disparity_error (health[27:24]),
    .i_pcie_not_in_table    (health[31:28]),
    .i_sata_tx_comm_wake    (tx_comm_wake),
    .i_sata_tx_comm_init    (tx_comm_init),
    .o_sata_reset           (o_sata_reset),
    .o_pcie_reset           (o_pcie_reset),
    .o_rx_pre_amp           (o_rx_pre_amp),
    .o_tx_diff_swing        (o_tx_diff_swing),
    .o_sata_comm_start      (o_sata_comm_start),
    .o_sata_comm_type       (o_sata_comm_type),
    .o_sata_error           (o_sata_error),
    .o_pcie_error           (o_pcie_error),
    .o_platform_ready       (o_platform_ready)
  );

  // Error level of one lane from its health word
  function automatic logic lane_error(input logic [15:0] h);
    return (|h[11:8]) || (|h[15:12]) || !h[6];
  endfunction

  // Status word as the register map lays it out
  function automatic logic [31:0] status_word(input logic [31:0] h);
    logic [31:0] s;
    s = '0;
    s[ST_SATA_PLL_DETECT] = h[0];
    s[ST_PCIE_PLL_DETECT] = h[16];
    s[ST_SATA_RESET_DONE] = h[1];
    s[ST_PCIE_RESET_DONE] = h[17];
    s[ST_SATA_LOCKED]     = h[2];
    s[ST_PCIE_LOCKED]     = h[18];
    s[ST_SATA_RX_IDLE]    = h[3];
    s[ST_PCIE_RX_IDLE]    = h[19];
    s[ST_SATA_TX_IDLE]    = h[4];
    s[ST_PCIE_TX_IDLE]    = h[20];
    s[ST_SATA_LOSS_SYNC]  = h[5];
    s[ST_PCIE_LOSS_SYNC]  = h[21];
    s[ST_SATA_ALIGNED]    = h[6];
    s[ST_PCIE_ALIGNED]    = h[22];
    return s;
  endfunction

  task automatic add_row(input string name, input logic [31:0] h, input int op,
                         input logic [31:0] addr, input logic [31:0] data,
                         input int sel, input logic [31:0] exp);
    row_name.push_back(name);
    row_health.push_back(h);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_sel.push_back(sel);
    row_exp.push_back(exp);
  endtask

  task automatic build_table();
    logic [31:0] ok_h;
    logic [31:0] h;
    logic [31:0] err_exp;
    ok_h = {HEALTHY_LANE, HEALTHY_LANE};
    add_row("rst_ctl_read", ok_h, OP_READ, ADDR_CONTROL, 0, SEL_RDATA, CTL_RESET_VAL);
    add_row("rst_pre_amp", ok_h, OP_HOLD, 0, 1, SEL_PREAMP, 32'(TB_RX_PREAMP));
    add_row("rst_swing", ok_h, OP_HOLD, 0, 1, SEL_SWING, 32'(TB_TX_DIFF));
    add_row("rst_ready", ok_h, OP_HOLD, 0, 1, SEL_READY, 32'h1);
    add_row("ctl_set_resets", ok_h, OP_WRITE, ADDR_CONTROL, CTL_RESET_VAL | 32'h3,
            SEL_RESETS, 32'h3);
    add_row("ctl_ready_low", ok_h, OP_HOLD, 0, 1, SEL_READY, 32'h0);
    add_row("ctl_readback", ok_h, OP_READ, ADDR_CONTROL, 0, SEL_RDATA, CTL_RESET_VAL | 32'h3);
    add_row("ctl_release", ok_h, OP_WRITE, ADDR_CONTROL, CTL_RESET_VAL, SEL_RESETS, 32'h0);
    add_row("ctl_ready_high", ok_h, OP_HOLD, 0, 1, SEL_READY, 32'h1);
    // Thin out the per-byte error flags so clean lanes show up too
    for (int k = 0; k < 6; k++) begin
      h = $random(seed) & ($random(seed) | 32'h00ff_00ff);
      err_exp = {30'h0, lane_error(h[31:16]), lane_error(h[15:0])};
      add_row($sformatf("rand_status_%0d", k), h, OP_READ, ADDR_STATUS, 0, SEL_RDATA,
              status_word(h));
      add_row($sformatf("rand_errors_%0d", k), h, OP_HOLD, 0, 1, SEL_ERRORS, err_exp);
    end
    add_row("cnt_pre_clear", ok_h, OP_WRITE, ADDR_ERR_CLEAR, 0, SEL_ACK, 32'h1);
    add_row("cnt_sata_zero", ok_h, OP_READ, ADDR_SATA_ERRS, 0, SEL_RDATA, 32'h0);
    add_row("cnt_sata_hold", {HEALTHY_LANE, 16'h0147}, OP_HOLD, 0, 5, SEL_ERRORS, 32'h1);
    add_row("cnt_sata_read", ok_h, OP_READ, ADDR_SATA_ERRS, 0, SEL_RDATA, 32'd5);
    add_row("cnt_pcie_hold", {16'h1047, HEALTHY_LANE}, OP_HOLD, 0, 3, SEL_ERRORS, 32'h2);
    add_row("cnt_pcie_read", ok_h, OP_READ, ADDR_PCIE_ERRS, 0, SEL_RDATA, 32'd3);
    add_row("int_enable", ok_h, OP_WRITE, ADDR_CONTROL, CTL_RESET_VAL | 32'h4, SEL_ACK, 32'h1);
    add_row("int_high", ok_h, OP_HOLD, 0, 2, SEL_INT, 32'h1);
    add_row("cnt_clear", ok_h, OP_WRITE, ADDR_ERR_CLEAR, 0, SEL_ACK, 32'h1);
    add_row("cnt_sata_cleared", ok_h, OP_READ, ADDR_SATA_ERRS, 0, SEL_RDATA, 32'h0);
    add_row("cnt_pcie_cleared", ok_h, OP_READ, ADDR_PCIE_ERRS, 0, SEL_RDATA, 32'h0);
    add_row("int_low", ok_h, OP_HOLD, 0, 2, SEL_INT, 32'h0);
    // OOB expected value is pulse count in bits 7:4, last type in bit 0
    add_row("oob_wake", ok_h, OP_WAKE, 0, 0, SEL_OOB, 32'h11);
    add_row("oob_init", ok_h, OP_INIT, 0, 0, SEL_OOB, 32'h10);
    add_row("oob_both", ok_h, OP_BOTH, 0, 0, SEL_OOB, 32'h20);
    add_row("oob_no_done", {HEALTHY_LANE, 16'h0045}, OP_WAKE, 0, 0, SEL_OOB, 32'h00);
    add_row("oob_after_done", ok_h, OP_WAKE, 0, 0, SEL_OOB, 32'h11);
  endtask

  // One Wishbone access, called and left on a falling edge
  task automatic wb_access(input logic we, input logic [31:0] addr,
                           input logic [31:0] data, input string name);
    int waited;
    waited  = 0;
    wbs_cyc = 1'b1;
    wbs_stb = 1'b1;
    wbs_we  = we;
    wbs_adr = addr;
    wbs_dat = data;
    wbs_sel = 4'hf;
    @(negedge clk);
    while (!o_wbs_ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ack_ok  = o_wbs_ack;
    rd_data = o_wbs_dat;
    wbs_cyc = 1'b0;
    wbs_stb = 1'b0;
    wbs_we  = 1'b0;
    if (!ack_ok) begin
      $display("Test %s: no Wishbone ack within %0d cycles", name, ACK_TIMEOUT);
      fail_count++;
    end
    @(negedge clk);
  endtask

  task automatic oob_strobe(input logic wake, input logic init);
    pulse_base   = pulse_total;
    tx_comm_wake = wake;
    tx_comm_init = init;
    @(negedge clk);
    tx_comm_wake = 1'b0;
    tx_comm_init = 1'b0;
    repeat (OOB_WINDOW) @(negedge clk);
  endtask

  function automatic logic [31:0] observe(input int sel);
    logic [31:0] pulses;
    pulses = 32'(pulse_total - pulse_base);
    case (sel)
      SEL_RDATA:  return rd_data;
      SEL_ACK:    return {31'h0, ack_ok};
      SEL_PREAMP: return {30'h0, o_rx_pre_amp};
      SEL_SWING:  return {28'h0, o_tx_diff_swing};
      SEL_RESETS: return {30'h0, o_pcie_reset, o_sata_reset};
      SEL_READY:  return {31'h0, o_platform_ready};
      SEL_ERRORS: return {30'h0, o_pcie_error, o_sata_error};
      SEL_INT:    return {31'h0, o_wbs_int};
      SEL_OOB:    return (pulses << 4) | {31'h0, last_type && (pulses != 0)};
      default:    return 32'hdead_beef;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected === actual) begin
      pass_count++;
      $display("ok  %s value %h", name, actual);
    end else begin
      fail_count++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Start pulses are one cycle wide, so one sample per cycle sees each once
  always @(negedge clk) begin
    if (o_sata_comm_start) begin
      pulse_total <= pulse_total + 1;
      last_type   <= o_sata_comm_type;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run stopped after %0d cycles before the table was done", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    health       = {HEALTHY_LANE, HEALTHY_LANE};
    wbs_cyc      = 1'b0;
    wbs_stb      = 1'b0;
    wbs_we       = 1'b0;
    wbs_adr      = 32'h0;
    wbs_dat      = 32'h0;
    wbs_sel      = 4'h0;
    tx_comm_wake = 1'b0;
    tx_comm_init = 1'b0;
    rd_data      = 32'h0;
    ack_ok       = 1'b0;
    seed         = 32'h9c15;
    build_table();
    cycle_limit = 40 * row_name.size() + 100;
    wait (!rst);
    @(negedge clk);
    for (int r = 0; r < row_name.size(); r++) begin
      health = row_health[r];
      case (row_op[r])
        OP_READ:  wb_access(1'b0, row_addr[r], 32'h0, row_name[r]);
        OP_WRITE: wb_access(1'b1, row_addr[r], row_data[r], row_name[r]);
        OP_HOLD:  repeat (row_data[r]) @(negedge clk);
        OP_WAKE:  oob_strobe(1'b1, 1'b0);
        OP_INIT:  oob_strobe(1'b0, 1'b1);
        OP_BOTH:  oob_strobe(1'b1, 1'b1);
        default:  @(negedge clk);
      endcase
      check_value(row_name[r], row_exp[r], observe(row_sel[r]));
    end
    $display("%0d tests, %0d passed, %0d failures", row_name.size(), pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
hdl/gtp_pkg.sv
hdl/lane_monitor.sv
hdl/sata_oob_ctrl.sv
hdl/wb_gtp_regs.sv
hdl/gtp_platform_top.sv
sim/clk_gen.sv
sim/tb_gtp_platform.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_gtp_platform \
  -o tb_gtp_platform > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_gtp_platform > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "Simulator exited with an error" sim.log && exit 1
exit 0
